// File: Makefile
# Verilator flow for the router output stage testbench
SIM := obj_dir/Vnoc_out_stage_tb
SRC := $(wildcard source/*.sv tb/*.sv)

.PHONY: all run clean

all: run

# Rebuilt only when a source or the file list changes
$(SIM): build.f $(SRC)
	verilator --binary --timing --assert --top-module noc_out_stage_tb -Mdir obj_dir -f build.f

run: $(SIM)
	$(SIM) | tee sim.log
	grep -qx "TB PASSED" sim.log

clean:
	rm -rf obj_dir sim.log

// File: build.f
source/noc_pkg.sv
source/noc_arb_rr.sv
source/noc_flit_fifo.sv
source/noc_in_port.sv
source/noc_out_switch.sv
source/noc_out_stage.sv
tb/noc_out_stage_tb.sv

// File: source/noc_arb_rr.sv
// Round-robin next-grant logic, purely combinational
// gnt must be one-hot, the grant register lives in the caller
`timescale 1ns/1ps

module noc_arb_rr (
  input  noc_pkg::grant_t req,
  input  logic            en,
  input  noc_pkg::grant_t gnt,
  output noc_pkg::grant_t nxt_gnt
);
  import noc_pkg::*;

  // mask[i][j] high when port j ranks above port i
  grant_t mask [NUM_PORTS];

  ////////////////////////////////////////
  // Priority masks
  ////////////////////////////////////////

  // Walk downward from i-1 with wrap until the current holder is met
  // Every port passed on the way is served before port i
  always_comb begin
    logic run;
    int   j;
    run = 1'b1;
    j   = 0;
    for (int i = 0; i < NUM_PORTS; i++) begin
      mask[i] = '0;
      run     = 1'b1;
      for (int d = 1; d < NUM_PORTS; d++) begin
        j          = (i - d + NUM_PORTS) % NUM_PORTS;
        // Stop at the holder, it ranks last
        run        = run & ~gnt[j];
        mask[i][j] = run;
      end
    end
  end

  ////////////////////////////////////////
  // Next grant
  ////////////////////////////////////////

  always_comb begin
    for (int k = 0; k < NUM_PORTS; k++) begin
      if (!en) begin
        // Frozen while a packet holds the output
        nxt_gnt[k] = gnt[k];
      end else begin
        // Winner has no higher ranked requester, idle keeps the holder
        nxt_gnt[k] = (req[k] & ~|(mask[k] & req)) | (~|req & gnt[k]);
      end
    end
  end

  // One-hot in gives one-hot out
  always_comb begin
    if ($onehot(gnt)) begin
      assert ($onehot(nxt_gnt)) else $error("arbiter next grant is not one-hot");
    end
  end

endmodule

// File: source/noc_flit_fifo.sv
// Show-ahead flit FIFO, FIFO_DEPTH entries
// Head flit is valid on rd_flit whenever empty is low
// Writes while full and reads while empty are ignored
`timescale 1ns/1ps

module noc_flit_fifo (
  input  logic           clk,
  input  logic           rst,
  input  logic           wr_en,
  input  noc_pkg::flit_t wr_flit,
  input  logic           rd_en,
  output noc_pkg::flit_t rd_flit,
  output logic           full,
  output logic           empty
);
  import noc_pkg::*;

  // Storage, no reset on payload
  flit_t            mem [FIFO_DEPTH];
  logic [PTR_W-1:0] wr_ptr;
  logic [PTR_W-1:0] rd_ptr;
  // One bit wider than the pointers to tell full from empty
  logic [PTR_W:0]   count;
  logic             do_wr;
  logic             do_rd;

  ////////////////////////////////////////
  // Flags and head
  ////////////////////////////////////////

  assign full    = (count == (PTR_W+1)'(FIFO_DEPTH));
  assign empty   = (count == '0);
  assign do_wr   = wr_en && !full;
  assign do_rd   = rd_en && !empty;

  // Show-ahead read port
  assign rd_flit = mem[rd_ptr];

  ////////////////////////////////////////
  // Storage and pointers
  ////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (do_wr) begin
      mem[wr_ptr] <= wr_flit;
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (do_wr) begin
        wr_ptr <= wr_ptr + 1'b1;
      end
      if (do_rd) begin
        rd_ptr <= rd_ptr + 1'b1;
      end
      // Simultaneous push and pop leave the count alone
      case ({do_wr, do_rd})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

  // Producer honours full, consumer honours empty
  a_no_overflow: assert property (@(posedge clk) disable iff (rst) wr_en |-> !full)
    else $error("flit FIFO written while full");
  a_no_underflow: assert property (@(posedge clk) disable iff (rst) rd_en |-> !empty)
    else $error("flit FIFO read while empty");

endmodule

// File: source/noc_in_port.sv
// Wishbone classic slave for one input channel, writes only
// Answer comes one cycle after the request, ack waits while the FIFO is full
`timescale 1ns/1ps

module noc_in_port (
  input  logic                       clk,
  input  logic                       rst,
  input  logic                       cyc,
  input  logic                       stb,
  input  noc_pkg::flit_kind_t        adr,
  input  logic [noc_pkg::FLIT_W-1:0] dat,
  input  logic                       full,
  output logic                       ack,
  output logic                       err,
  output logic                       wr_en,
  output noc_pkg::flit_t             wr_flit
);
  import noc_pkg::*;

  logic in_pkt;   // head seen, tail not yet
  logic req;      // access pending and not yet answered
  logic legal;    // flit fits the packet framing

  ////////////////////////////////////////
  // Framing check
  ////////////////////////////////////////

  // Master still holds stb in the answer cycle, so skip that one
  assign req = cyc && stb && !ack && !err;

  always_comb begin
    if (in_pkt) begin
      legal = (adr == KIND_BODY) || (adr == KIND_TAIL);
    end else begin
      legal = (adr == KIND_HEAD) || (adr == KIND_SINGLE);
    end
  end

  // FIFO write on the same edge that raises ack
  assign wr_en        = req && legal && !full;
  assign wr_flit.kind = adr;
  assign wr_flit.data = dat;

  ////////////////////////////////////////
  // Answer and packet state
  ////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (rst) begin
      ack    <= 1'b0;
      err    <= 1'b0;
      in_pkt <= 1'b0;
    end else begin
      ack <= wr_en;
      // Errors go out regardless of FIFO room
      err <= req && !legal;
      if (wr_en) begin
        case (adr)
          KIND_HEAD: in_pkt <= 1'b1;
          KIND_TAIL: in_pkt <= 1'b0;
          default:   in_pkt <= in_pkt;   // body and single keep state
        endcase
      end
    end
  end

  // An answer always meets a master that still holds the access
  a_answer_held: assert property (@(posedge clk) disable iff (rst)
    (ack || err) |-> (cyc && stb))
    else $error("input port answered a write the master no longer holds");

endmodule

// File: source/noc_out_stage.sv
// Output stage top, NUM_PORTS Wishbone input channels to one downstream link
// Routing, virtual channels and credit flow control are not part of this stage
`timescale 1ns/1ps

module noc_out_stage (
  input  logic                                                clk,
  input  logic                                                rst,
  input  logic [noc_pkg::NUM_PORTS-1:0]                       in_cyc,
  input  logic [noc_pkg::NUM_PORTS-1:0]                       in_stb,
  input  noc_pkg::flit_kind_t [noc_pkg::NUM_PORTS-1:0]        in_adr,
  input  logic [noc_pkg::NUM_PORTS-1:0][noc_pkg::FLIT_W-1:0]  in_dat,
  output logic [noc_pkg::NUM_PORTS-1:0]                       in_ack,
  output logic [noc_pkg::NUM_PORTS-1:0]                       in_err,
  input  logic                                                out_ack,
  output logic                                                out_cyc,
  output logic                                                out_stb,
  output logic [noc_pkg::PORT_W+1:0]                          out_adr,
  output logic [noc_pkg::FLIT_W-1:0]                          out_dat
);
  import noc_pkg::*;

  // Input port to FIFO
  logic [NUM_PORTS-1:0]  wr_en;
  flit_t [NUM_PORTS-1:0] wr_flit;
  logic [NUM_PORTS-1:0]  full;
  // FIFO to switch
  flit_t [NUM_PORTS-1:0] rd_flit;
  logic [NUM_PORTS-1:0]  empty;
  logic [NUM_PORTS-1:0]  rd_en;

  ////////////////////////////////////////
  // Per channel slave and buffer
  ////////////////////////////////////////

  for (genvar p = 0; p < NUM_PORTS; p++) begin : g_chan
    noc_in_port u_in_port (
      .clk     (clk),
      .rst     (rst),
      .cyc     (in_cyc[p]),
      .stb     (in_stb[p]),
      .adr     (in_adr[p]),
      .dat     (in_dat[p]),
      .full    (full[p]),
      .ack     (in_ack[p]),
      .err     (in_err[p]),
      .wr_en   (wr_en[p]),
      .wr_flit (wr_flit[p])
    );

    noc_flit_fifo u_fifo (
      .clk     (clk),
      .rst     (rst),
      .wr_en   (wr_en[p]),
      .wr_flit (wr_flit[p]),
      .rd_en   (rd_en[p]),
      .rd_flit (rd_flit[p]),
      .full    (full[p]),
      .empty   (empty[p])
    );
  end

  // Shared output link
  noc_out_switch u_switch (
    .clk     (clk),
    .rst     (rst),
    .rd_flit (rd_flit),
    .empty   (empty),
    .out_ack (out_ack),
    .rd_en   (rd_en),
    .out_cyc (out_cyc),
    .out_stb (out_stb),
    .out_adr (out_adr),
    .out_dat (out_dat)
  );

endmodule

// File: source/noc_out_switch.sv
// Output switch with grant register, packet lock and Wishbone classic master
// out_cyc is held from the first flit of a packet until the ack of its tail
`timescale 1ns/1ps

module noc_out_switch (
  input  logic                                    clk,
  input  logic                                    rst,
  input  noc_pkg::flit_t [noc_pkg::NUM_PORTS-1:0] rd_flit,
  input  logic [noc_pkg::NUM_PORTS-1:0]           empty,
  input  logic                                    out_ack,
  output logic [noc_pkg::NUM_PORTS-1:0]           rd_en,
  output logic                                    out_cyc,
  output logic                                    out_stb,
  output logic [noc_pkg::PORT_W+1:0]              out_adr,
  output logic [noc_pkg::FLIT_W-1:0]              out_dat
);
  import noc_pkg::*;

  grant_t    req;       // channels with a flit waiting
  grant_t    gnt;       // current grant register
  grant_t    nxt_gnt;
  logic      locked;    // packet owns the downstream link
  logic      arb_en;
  port_idx_t sel;       // index of the granted channel
  flit_t     head;      // granted FIFO head
  logic      pop;
  logic      last;      // head closes the packet

  ////////////////////////////////////////
  // Arbitration
  ////////////////////////////////////////

  assign req    = ~empty;
  // Grant only moves between packets
  assign arb_en = !locked;

  noc_arb_rr u_arb (
    .req     (req),
    .en      (arb_en),
    .gnt     (gnt),
    .nxt_gnt (nxt_gnt)
  );

  // One-hot grant to channel index
  always_comb begin
    sel = '0;
    for (int p = 0; p < NUM_PORTS; p++) begin
      if (gnt[p]) begin
        sel = port_idx_t'(p);
      end
    end
  end

  ////////////////////////////////////////
  // Master port
  ////////////////////////////////////////

  assign head    = rd_flit[sel];
  assign out_cyc = locked;
  // Strobe drops while the locked channel has nothing yet
  assign out_stb = locked && !empty[sel];
  // Source channel above the flit kind
  assign out_adr = {sel, head.kind};
  assign out_dat = head.data;

  assign pop   = out_stb && out_ack;
  assign last  = (head.kind == KIND_TAIL) || (head.kind == KIND_SINGLE);
  // Pop only the granted FIFO
  assign rd_en = pop ? gnt : '0;

  ////////////////////////////////////////
  // Grant register and lock
  ////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (rst) begin
      // Last port holds the grant, so port 0 wins first
      gnt    <= {1'b1, {(NUM_PORTS-1){1'b0}}};
      locked <= 1'b0;
    end else if (!locked) begin
      gnt    <= nxt_gnt;
      // Lock as soon as some channel is waiting
      locked <= |req;
    end else if (pop && last) begin
      // Tail acked, arbitrate again next cycle
      locked <= 1'b0;
    end
  end

  // Wishbone master keeps address and data while waiting for ack
  a_hold_stable: assert property (@(posedge clk) disable iff (rst)
    (out_stb && !out_ack) |=> ($stable(out_adr) && $stable(out_dat)))
    else $error("downstream address or data changed before ack");

endmodule

// File: source/noc_pkg.sv
// Shared sizes and flit types for the mesh router output stage
// FIFO_DEPTH must be a power of two so the FIFO pointers wrap on their own
package noc_pkg;

  ////////////////////////////////////////
  // Sizes
  ////////////////////////////////////////

  // Input channels feeding the output stage
  localparam int NUM_PORTS = 4;

  // Bits of a channel index
  localparam int PORT_W = 2;

  // Flit payload width
  localparam int FLIT_W = 32;

  // Flits held per channel FIFO
  localparam int FIFO_DEPTH = 4;

  // FIFO pointer width
  localparam int PTR_W = $clog2(FIFO_DEPTH);

  ////////////////////////////////////////
  // Types
  ////////////////////////////////////////

  // Flit kind as carried on the Wishbone address
  typedef enum logic [1:0] {
    KIND_BODY   = 2'd0,
    KIND_HEAD   = 2'd1,
    KIND_TAIL   = 2'd2,
    KIND_SINGLE = 2'd3   // head and tail in one flit
  } flit_kind_t;

  // Flit as stored in the channel FIFOs, 34 bits
  typedef struct packed {
    flit_kind_t          kind;
    logic [FLIT_W-1:0]   data;
  } flit_t;

  // Channel index
  typedef logic [PORT_W-1:0] port_idx_t;

  // One-hot grant vector, one bit per channel
  typedef logic [NUM_PORTS-1:0] grant_t;

endpackage

// File: tb/noc_out_stage_tb.sv
// Directed testbench for the router output stage, five tests in sequence
// Downstream responder acks each strobe at once or after 0 to 3 random cycles
`timescale 1ns/1ps

module noc_out_stage_tb;
  import noc_pkg::*;

  // 4 + 6 + 6 + 5 + 7 flits over all tests
  localparam int TOTAL_FLITS  = 28;
  localparam int ANSWER_LIMIT = 100;
  localparam int RX_LIMIT     = 200;

  logic                             clk;
  logic                             rst;
  logic [NUM_PORTS-1:0]             in_cyc;
  logic [NUM_PORTS-1:0]             in_stb;
  flit_kind_t [NUM_PORTS-1:0]       in_adr;
  logic [NUM_PORTS-1:0][FLIT_W-1:0] in_dat;
  logic [NUM_PORTS-1:0]             in_ack;
  logic [NUM_PORTS-1:0]             in_err;
  logic                             out_ack;
  logic                             out_cyc;
  logic                             out_stb;
  logic [PORT_W+1:0]                out_adr;
  logic [FLIT_W-1:0]                out_dat;

  // Responder controls
  logic      stall;
  logic      rand_delay;
  integer    seed;
  // Accepted flits per channel, and what left downstream
  flit_t     exp_q [NUM_PORTS][$];
  flit_t     rx_flit [$];
  port_idx_t rx_port [$];
  logic      cyc_prev;
  int        cyc_drops;
  int        errors;
  int        n_pass;
  int        n_fail;
  string     cur_test;

  noc_out_stage dut (.*);

  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  // Falling edges of out_cyc, one per finished packet
  always @(posedge clk) begin
    if (rst) begin
      cyc_prev  <= 1'b0;
      cyc_drops <= 0;
    end else begin
      cyc_prev <= out_cyc;
      if (cyc_prev && !out_cyc) begin
        cyc_drops <= cyc_drops + 1;
      end
    end
  end

  ////////////////////////////////////////
  // Downstream responder and collector
  ////////////////////////////////////////

  initial begin : responder
    int delay;
    seed = 34;
    out_ack <= 1'b0;
    forever begin
      @(posedge clk);
      if (rst) begin
        rx_flit.delete();
        rx_port.delete();
        out_ack <= 1'b0;
      end else if (out_stb && !out_ack && !stall) begin
        delay = rand_delay ? $unsigned($random(seed)) % 4 : 0;
        repeat (delay) @(posedge clk);
        out_ack <= 1'b1;
        // Flit is still on the bus at the ack edge
        @(posedge clk);
        rx_flit.push_back(flit_t'({out_adr[1:0], out_dat}));
        rx_port.push_back(out_adr[PORT_W+1:2]);
        out_ack <= 1'b0;
      end
    end
  end

  initial begin : watchdog
    repeat (TOTAL_FLITS * 20) @(posedge clk);
    $display("ERROR: watchdog expired after %0d cycles, the run did not finish",
             TOTAL_FLITS * 20);
    $display("TB FAILED");
    $finish;
  end

  ////////////////////////////////////////
  // Compare tasks
  ////////////////////////////////////////

  task automatic check_flit(input string what, input flit_t exp, input flit_t act);
    if (act !== exp) begin
      $display("MISMATCH %s %s expected kind %0d data %h actual kind %0d data %h",
               cur_test, what, exp.kind, exp.data, act.kind, act.data);
      errors++;
    end
  endtask

  task automatic check_port(input string what, input port_idx_t exp, input port_idx_t act);
    if (act !== exp) begin
      $display("MISMATCH %s %s expected %0d actual %0d", cur_test, what, exp, act);
      errors++;
    end
  endtask

  task automatic check_bit(input string what, input logic exp, input logic act);
    if (act !== exp) begin
      $display("MISMATCH %s %s expected %b actual %b", cur_test, what, exp, act);
      errors++;
    end
  endtask

  ////////////////////////////////////////
  // Drivers and helpers
  ////////////////////////////////////////

  task automatic apply_reset();
    rst <= 1'b1;
    repeat (10) @(posedge clk);
    rst <= 1'b0;
    for (int p = 0; p < NUM_PORTS; p++) begin
      exp_q[p].delete();
    end
    @(posedge clk);
  endtask

  // One Wishbone write, held until ack or err
  task automatic write_flit(input int ch, input flit_kind_t kind, input logic [FLIT_W-1:0] data,
                            output logic got_ack, output logic got_err);
    int waited;
    waited = 0;
    @(posedge clk);
    in_cyc[ch] <= 1'b1;
    in_stb[ch] <= 1'b1;
    in_adr[ch] <= kind;
    in_dat[ch] <= data;
    do begin
      @(posedge clk);
      got_ack = in_ack[ch];
      got_err = in_err[ch];
      waited++;
    end while (!got_ack && !got_err && waited < ANSWER_LIMIT);
    in_cyc[ch] <= 1'b0;
    in_stb[ch] <= 1'b0;
    if (!got_ack && !got_err) begin
      $display("ERROR: %s channel %0d gave no answer to a write", cur_test, ch);
      errors++;
    end
    if (got_ack) begin
      exp_q[ch].push_back(flit_t'({kind, data}));
    end
  endtask

  // Head, bodies and tail, or one single flit when len is 1
  task automatic send_packet(input int ch, input int len, input logic [FLIT_W-1:0] base);
    flit_kind_t kind;
    logic       ack;
    logic       err;
    for (int i = 0; i < len; i++) begin
      kind = (len == 1) ? KIND_SINGLE :
             (i == 0) ? KIND_HEAD :
             (i == len - 1) ? KIND_TAIL : KIND_BODY;
      write_flit(ch, kind, base + i, ack, err);
      check_bit("packet flit acked", 1'b1, ack);
    end
  endtask

  task automatic wait_rx(input int n);
    int waited;
    waited = 0;
    while (rx_flit.size() < n && waited < RX_LIMIT) begin
      @(posedge clk);
      waited++;
    end
    if (rx_flit.size() < n) begin
      $display("ERROR: %s expected %0d downstream flits but only %0d arrived",
               cur_test, n, rx_flit.size());
      errors++;
    end
    // Lock release and out_cyc drop
    repeat (3) @(posedge clk);
  endtask

  // Each downstream flit against its channel queue, and no interleaving
  task automatic check_stream();
    for (int i = 0; i < rx_flit.size(); i++) begin
      if (exp_q[rx_port[i]].size() == 0) begin
        $display("ERROR: %s flit %0d from channel %0d was never accepted upstream",
                 cur_test, i, rx_port[i]);
        errors++;
      end else begin
        check_flit("downstream flit", exp_q[rx_port[i]].pop_front(), rx_flit[i]);
      end
      // Channel may change only after a tail or single
      if (i > 0 && rx_port[i] != rx_port[i-1] &&
          !(rx_flit[i-1].kind inside {KIND_TAIL, KIND_SINGLE})) begin
        $display("ERROR: %s packets interleaved at flit %0d", cur_test, i);
        errors++;
      end
    end
    for (int p = 0; p < NUM_PORTS; p++) begin
      if (exp_q[p].size() != 0) begin
        $display("ERROR: %s %0d accepted flits never left channel %0d",
                 cur_test, exp_q[p].size(), p);
        errors++;
      end
    end
  endtask

  task automatic finish_test(input int err_before);
    if (errors == err_before) begin
      n_pass++;
      $display("PASS %s", cur_test);
    end else begin
      n_fail++;
      $display("FAIL %s with %0d errors", cur_test, errors - err_before);
    end
  endtask

  ////////////////////////////////////////
  // Tests
  ////////////////////////////////////////

  task automatic test_single_packet();
    int e0;
    cur_test = "single_packet";
    e0 = errors;
    apply_reset();
    send_packet(2, 4, 32'hC0DE_2000);
    wait_rx(4);
    for (int i = 0; i < rx_port.size(); i++) begin
      check_port("source index", port_idx_t'(2), rx_port[i]);
    end
    // Only drop comes after the tail
    check_bit("out_cyc held over packet", 1'b1, cyc_drops == 1);
    check_stream();
    finish_test(e0);
  endtask

  task automatic test_round_robin();
    int e0;
    cur_test = "round_robin";
    e0 = errors;
    apply_reset();
    rand_delay <= 1'b1;
    stall      <= 1'b1;
    for (int p = 0; p < NUM_PORTS; p++) begin
      send_packet(p, 1, 32'h5100_0000 + p);
    end
    stall <= 1'b0;
    wait_rx(4);
    stall <= 1'b1;
    // Both requests meet the arbiter in the same cycle
    fork
      send_packet(1, 1, 32'h5200_0001);
      send_packet(3, 1, 32'h5200_0003);
    join
    stall <= 1'b0;
    wait_rx(6);
    for (int i = 0; i < NUM_PORTS; i++) begin
      check_port("first round order", port_idx_t'(i), rx_port[i]);
    end
    check_port("second round first", port_idx_t'(1), rx_port[4]);
    check_port("second round second", port_idx_t'(3), rx_port[5]);
    check_stream();
    finish_test(e0);
  endtask

  task automatic test_atomicity();
    int e0;
    cur_test = "atomicity";
    e0 = errors;
    apply_reset();
    rand_delay <= 1'b1;
    stall      <= 1'b1;
    fork
      send_packet(0, 3, 32'hA700_0000);
      send_packet(1, 3, 32'hA710_0000);
    join
    stall <= 1'b0;
    wait_rx(6);
    check_port("first granted channel", port_idx_t'(0), rx_port[0]);
    check_port("second granted channel", port_idx_t'(1), rx_port[3]);
    for (int i = 1; i < 3; i++) begin
      check_port("first packet source", port_idx_t'(0), rx_port[i]);
      check_port("second packet source", port_idx_t'(1), rx_port[i+3]);
    end
    check_stream();
    finish_test(e0);
  endtask

  task automatic test_back_pressure();
    int   e0;
    logic early;
    logic ack;
    logic err;
    cur_test = "back_pressure";
    e0 = errors;
    apply_reset();
    rand_delay <= 1'b0;
    stall      <= 1'b1;
    // Head and three bodies fill the FIFO while the link is stalled
    write_flit(1, KIND_HEAD, 32'hB900_0000, ack, err);
    check_bit("fill write acked", 1'b1, ack);
    for (int i = 1; i < FIFO_DEPTH; i++) begin
      write_flit(1, KIND_BODY, 32'hB900_0000 + i, ack, err);
      check_bit("fill write acked", 1'b1, ack);
    end
    early = 1'b0;
    fork
      write_flit(1, KIND_TAIL, 32'hB900_0004, ack, err);
      begin
        repeat (12) begin
          @(posedge clk);
          early = early | in_ack[1];
        end
        stall <= 1'b0;
      end
    join
    check_bit("fifth write held while full", 1'b0, early);
    check_bit("fifth write acked after release", 1'b1, ack);
    wait_rx(5);
    check_stream();
    finish_test(e0);
  endtask

  task automatic test_framing();
    int   e0;
    logic ack;
    logic err;
    cur_test = "framing";
    e0 = errors;
    apply_reset();
    write_flit(3, KIND_BODY, 32'hE300_0001, ack, err);
    check_bit("body outside packet refused", 1'b1, err);
    write_flit(3, KIND_TAIL, 32'hE300_0002, ack, err);
    check_bit("tail outside packet refused", 1'b1, err);
    write_flit(3, KIND_HEAD, 32'hE300_0003, ack, err);
    check_bit("opening head acked", 1'b1, ack);
    write_flit(3, KIND_HEAD, 32'hE300_0004, ack, err);
    check_bit("head inside packet refused", 1'b1, err);
    write_flit(3, KIND_TAIL, 32'hE300_0005, ack, err);
    check_bit("closing tail acked", 1'b1, ack);
    send_packet(3, 2, 32'hE300_0010);
    wait_rx(4);
    check_stream();
    finish_test(e0);
  endtask

  ////////////////////////////////////////
  // Sequence
  ////////////////////////////////////////

  initial begin
    rst        <= 1'b1;
    in_cyc     <= '0;
    in_stb     <= '0;
    in_dat     <= '0;
    stall      <= 1'b0;
    rand_delay <= 1'b0;
    errors = 0;
    n_pass = 0;
    n_fail = 0;
    for (int p = 0; p < NUM_PORTS; p++) begin
      in_adr[p] <= KIND_BODY;
    end
    test_single_packet();
    test_round_robin();
    test_atomicity();
    test_back_pressure();
    test_framing();
    $display("tests passed %0d failed %0d", n_pass, n_fail);
    if (n_fail == 0) begin
      $display("TB PASSED");
    end else begin
      $display("TB FAILED");
    end
    $finish;
  end

endmodule
